// File: conv_stimulus.txt
// Columns: record kind, hex value. Kinds: 0 header, 1 weight row, 2 pixel beat,
// 3 expected output beats of the layer, 4 end. Word 0 is the low byte.
// Layer 1: 3x3 kernel, cin 2, 2 columns, 2 blocks, 24 beats out.
0 000002020203
1 161514131211
1 262524232221
1 363534333231
1 464544434241
1 565554535251
1 666564636261
2 03020100
2 13121110
2 23222120
2 33323130
2 43424140
2 53525150
2 63626160
2 73727170
3 18
// Layer 2: 1x1 kernel, cin 1, 2 columns, 1 block, 2 beats out.
0 000001020101
1 767574737271
2 83828180
2 93929190
3 2
4 0

// File: flist.f
conv_geom_pkg.sv
conv_stream_pkg.sv
conv_ifs.sv
axis_slice.sv
conv_config_decode.sv
row_sequencer.sv
conv_beat_assembler.sv
conv_input_pipe.sv
conv_input_pipe_props.sv
conv_input_pipe_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal -f flist.f --top-module conv_input_pipe_tb -Mdir obj_dir
out=$(./obj_dir/Vconv_input_pipe_tb +verilator+error+limit+1000 2>&1) || true
echo "$out"
if echo "$out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1

// File: conv_input_pipe_tb.sv
`timescale 1ns/1ns

module conv_input_pipe_tb import conv_geom_pkg::*, conv_stream_pkg::*; ();

  localparam int stim_depth   = 64;
  localparam int drain_cycles = 20;

  logic                              aclk;
  logic                              rst_n;
  logic                              s_weights_tvalid;
  logic                              s_weights_tready;
  logic [w_words*word_width-1:0]     s_weights_tdata;
  logic                              s_weights_tlast;
  logic                              s_pixels_tvalid;
  logic                              s_pixels_tready;
  logic [im_in_words*word_width-1:0] s_pixels_tdata;
  logic                              s_pixels_tlast;
  logic                              m_conv_tvalid;
  logic                              m_conv_tready;
  logic [units*word_width-1:0]       m_conv_tdata_pixels;
  logic [w_words*word_width-1:0]     m_conv_tdata_weights;
  logic [tuser_width-1:0]            m_conv_tuser;
  logic                              m_conv_tlast;

  logic [w_words*word_width-1:0] stim [stim_depth];
  logic [w_words*word_width-1:0] w_beats [$];
  int                            w_need [$]; // Output beats due before this beat.
  pixel_beat_t                   p_beats [$];
  conv_beat_t                    exp_q [$];
  int                            errors, got_beats, total_beats;
  int                            cycles, limit, w_idx, p_idx;

  conv_input_pipe dut (.*);

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  // Builds the driver queues and the expected beats from the file.
  task automatic load_stimulus();
    weight_row_t                   wmem [w_rows_max];
    conv_beat_t                    e;
    logic [w_words*word_width-1:0] val;
    int kind, kh, cin, cols, blocks, n_w, pix_n, layer_beats;
    int ci, col, blk, k_last, base;
    $readmemh("conv_stimulus.txt", stim);
    kh = 1;
    cin = 1;
    cols = 1;
    blocks = 1;
    n_w = 0;
    pix_n = 0;
    layer_beats = 0;
    for (int i = 0; i + 1 < stim_depth; i += 2) begin
      kind = int'(stim[i]);
      val  = stim[i+1];
      if (kind == 4) break;
      case (kind)
        0: begin
          kh     = int'(val[h_kernel_h*word_width +: word_width]);
          cin    = int'(val[h_cin*word_width +: word_width]);
          cols   = int'(val[h_cols*word_width +: word_width]);
          blocks = int'(val[h_blocks*word_width +: word_width]);
          n_w = 0;
          pix_n = 0;
          layer_beats = 0;
          w_beats.push_back(val);
          w_need.push_back(total_beats); // Previous layer must be out first.
        end
        1: begin
          wmem[n_w] = val;
          n_w++;
          w_beats.push_back(val);
          w_need.push_back(0);
        end
        2: begin
          p_beats.push_back(val[im_in_words*word_width-1:0]);
          ci     = pix_n % cin;
          col    = (pix_n / cin) % cols;
          blk    = pix_n / (cin * cols);
          k_last = (kh == 1) ? 0 : kh - 1;
          for (int k = 0; k <= k_last; k++) begin
            base = (kh == 1) ? 1 : k; // Centre rows for 1x1.
            e = '0;
            for (int u = 0; u < units; u++) begin
              e.pixels[u] = val[(base + u) * word_width +: word_width];
            end
            e.weights                    = wmem[ci * kh + k];
            e.tuser[i_is_1x1]            = (kh == 1);
            e.tuser[i_is_top_block]      = (blk == 0);
            e.tuser[i_is_bottom_block]   = (blk == blocks - 1);
            e.tuser[i_is_col_last]       = (col == cols - 1);
            e.tuser[i_is_cin_last]       = (ci == cin - 1);
            e.tuser[i_kernel_row +: 2]   = 2'(k);
            e.last = (pix_n == cin * cols * blocks - 1) && (k == k_last);
            exp_q.push_back(e);
            layer_beats++;
          end
          pix_n++;
        end
        3: begin
          if (layer_beats != int'(val)) begin
            errors++;
            $display("Stimulus file lists %0d beats for a layer whose header gives %0d",
                     int'(val), layer_beats);
          end
          total_beats += int'(val);
        end
        default: begin
          errors++;
          $display("Unknown record kind %0d in the stimulus file", kind);
        end
      endcase
    end
  endtask

  task automatic report_mismatch(input string what, input logic [63:0] got,
                                 input logic [63:0] want);
    errors++;
    $display("[ERROR] %0t: beat %0d %s is %h, expected %h", $time, got_beats, what, got, want);
  endtask

  task automatic check_output();
    conv_beat_t e;
    if (m_conv_tvalid && m_conv_tready) begin
      got_beats++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("Extra output beat %0d at %0t with nothing left to expect", got_beats, $time);
      end else begin
        e = exp_q.pop_front();
        if (m_conv_tdata_pixels !== e.pixels)
          report_mismatch("pixels", 64'(m_conv_tdata_pixels), 64'(e.pixels));
        if (m_conv_tdata_weights !== e.weights)
          report_mismatch("weights", 64'(m_conv_tdata_weights), 64'(e.weights));
        if (m_conv_tuser !== e.tuser)
          report_mismatch("tuser", 64'(m_conv_tuser), 64'(e.tuser));
        if (m_conv_tlast !== e.last)
          report_mismatch("tlast", 64'(m_conv_tlast), 64'(e.last));
      end
    end
  endtask

  task automatic drive_weights();
    logic took;
    took = s_weights_tvalid && s_weights_tready;
    if (took) begin
      if (got_beats < w_need[w_idx]) begin
        errors++;
        $display("[ERROR] %0t: header taken after %0d of %0d output beats",
                 $time, got_beats, w_need[w_idx]);
      end
      w_idx++;
    end
    if (took || !s_weights_tvalid) begin
      if (w_idx < w_beats.size() && $urandom_range(3) != 0) begin
        s_weights_tvalid <= 1'b1;
        s_weights_tdata  <= w_beats[w_idx];
      end else begin
        s_weights_tvalid <= 1'b0;
      end
    end
  endtask

  task automatic drive_pixels();
    logic took;
    took = s_pixels_tvalid && s_pixels_tready;
    if (took) p_idx++;
    if (took || !s_pixels_tvalid) begin
      if (p_idx < p_beats.size() && $urandom_range(3) != 0) begin
        s_pixels_tvalid <= 1'b1;
        s_pixels_tdata  <= p_beats[p_idx];
      end else begin
        s_pixels_tvalid <= 1'b0;
      end
    end
  endtask

  task automatic step_cycle();
    cycles++;
    check_output();
    drive_weights();
    drive_pixels();
    m_conv_tready <= ($urandom_range(3) != 0);
  endtask

  initial begin : run_test
    void'($urandom(32'hcfef_3b3f));
    rst_n            = 1'b0;
    s_weights_tvalid = 1'b0;
    s_weights_tdata  = '0;
    s_weights_tlast  = 1'b0;
    s_pixels_tvalid  = 1'b0;
    s_pixels_tdata   = '0;
    s_pixels_tlast   = 1'b0;
    m_conv_tready    = 1'b0;
    errors      = 0;
    got_beats   = 0;
    total_beats = 0;
    cycles      = 0;
    w_idx       = 0;
    p_idx       = 0;
    load_stimulus();
    limit = 20 * total_beats + 200;
    repeat (2) @(posedge aclk);
    rst_n <= 1'b1;
    while (got_beats < total_beats && cycles < limit) begin
      @(posedge aclk);
      step_cycle();
    end
    if (got_beats < total_beats) begin
      errors++;
      $display("Timeout after %0d cycles with %0d of %0d output beats received",
               cycles, got_beats, total_beats);
    end else begin
      repeat (drain_cycles) begin // Catches duplicated beats.
        @(posedge aclk);
        step_cycle();
      end
    end
    if (total_beats == 0) begin
      errors++;
      $display("The stimulus file gave no output beats to expect");
    end
    $display("Summary: %0d errors, %0d assertion failures, %0d of %0d beats received",
             errors, dut.u_props.fail_count, got_beats, total_beats);
    if (errors == 0 && dut.u_props.fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: conv_input_pipe_props.sv
`timescale 1ns/1ns

module conv_input_pipe_props import conv_geom_pkg::*, conv_stream_pkg::*; (
  input logic                          aclk,
  input logic                          rst_n,
  input logic                          m_conv_tvalid,
  input logic                          m_conv_tready,
  input logic [units*word_width-1:0]   m_conv_tdata_pixels,
  input logic [w_words*word_width-1:0] m_conv_tdata_weights,
  input logic [tuser_width-1:0]        m_conv_tuser,
  input logic                          m_conv_tlast,
  input logic                          s_weights_tvalid,
  input logic [w_words*word_width-1:0] s_weights_tdata,
  input logic                          s_pixels_tready,
  input logic                          s_weights_tready
);

  int unsigned fail_count = 0;
  logic [1:0]  krow;
  logic        hdr_seen;
  logic        w_all_in; // Header and all weight rows in.
  int unsigned w_seen;
  int unsigned w_due;

  assign krow = m_conv_tuser[i_kernel_row +: 2];

  // Weight rows counted against cin times kernel height.
  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      hdr_seen <= 1'b0;
      w_all_in <= 1'b0;
      w_seen   <= 0;
      w_due    <= 0;
    end else if (m_conv_tvalid && m_conv_tready && m_conv_tlast) begin
      w_all_in <= 1'b0;
    end else if (s_weights_tvalid && s_weights_tready) begin
      if (!hdr_seen) begin
        hdr_seen <= 1'b1;
        w_seen   <= 0;
        w_due    <= int'(s_weights_tdata[h_cin*word_width +: word_width])
                    * int'(s_weights_tdata[h_kernel_h*word_width +: word_width]);
      end else begin
        w_seen <= w_seen + 1;
        if (w_seen + 1 == w_due) begin
          w_all_in <= 1'b1;
          hdr_seen <= 1'b0;
        end
      end
    end
  end

  a_hold_on_stall: assert property (@(posedge aclk) disable iff (!rst_n)
    m_conv_tvalid && !m_conv_tready |=> m_conv_tvalid
      && $stable({m_conv_tdata_pixels, m_conv_tdata_weights, m_conv_tuser, m_conv_tlast}))
    else begin
      $error("m_conv beat changed or dropped while stalled");
      fail_count++;
    end

  a_pixels_after_load: assert property (@(posedge aclk) disable iff (!rst_n)
    s_pixels_tready |-> w_all_in)
    else begin
      $error("s_pixels_tready high before the weights were loaded");
      fail_count++;
    end

  a_krow_range: assert property (@(posedge aclk) disable iff (!rst_n)
    m_conv_tvalid |-> krow < (m_conv_tuser[i_is_1x1] ? 2'd1 : 2'(kernel_h_max)))
    else begin
      $error("tuser kernel row %0d not below the kernel height", krow);
      fail_count++;
    end

endmodule

bind conv_input_pipe conv_input_pipe_props u_props (
  .aclk                 (aclk),
  .rst_n                (rst_n),
  .m_conv_tvalid        (m_conv_tvalid),
  .m_conv_tready        (m_conv_tready),
  .m_conv_tdata_pixels  (m_conv_tdata_pixels),
  .m_conv_tdata_weights (m_conv_tdata_weights),
  .m_conv_tuser         (m_conv_tuser),
  .m_conv_tlast         (m_conv_tlast),
  .s_weights_tvalid     (s_weights_tvalid),
  .s_weights_tdata      (s_weights_tdata),
  .s_pixels_tready      (s_pixels_tready),
  .s_weights_tready     (s_weights_tready)
);

// File: conv_input_pipe.sv
`timescale 1ns/1ns

module conv_input_pipe import conv_geom_pkg::*, conv_stream_pkg::*; (
  input  logic                          aclk,
  input  logic                          rst_n,
  input  logic                          s_weights_tvalid,
  output logic                          s_weights_tready,
  input  logic [w_words*word_width-1:0] s_weights_tdata,
  input  logic                          s_weights_tlast,
  input  logic                          s_pixels_tvalid,
  output logic                          s_pixels_tready,
  input  logic [im_in_words*word_width-1:0] s_pixels_tdata,
  input  logic                          s_pixels_tlast,
  output logic                          m_conv_tvalid,
  input  logic                          m_conv_tready,
  output logic [units*word_width-1:0]   m_conv_tdata_pixels,
  output logic [w_words*word_width-1:0] m_conv_tdata_weights,
  output logic [tuser_width-1:0]        m_conv_tuser,
  output logic                          m_conv_tlast
);

  // Layers are framed by counts from the header, tlast is not looked at.
  cfg_if cfg_bus ();
  row_if row_bus ();

  pixel_beat_t pix_data;
  logic        pix_valid;
  logic        pix_ready;
  logic        pix_in_ready;
  conv_beat_t  m_data;

  assign s_pixels_tready = cfg_bus.loaded && pix_in_ready;

  axis_slice #(
    .payload_t (pixel_beat_t)
  ) u_pix_slice (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .in_valid  (s_pixels_tvalid && cfg_bus.loaded),
    .in_ready  (pix_in_ready),
    .in_data   (s_pixels_tdata),
    .out_valid (pix_valid),
    .out_ready (pix_ready),
    .out_data  (pix_data)
  );

  conv_config_decode u_decode (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .s_valid (s_weights_tvalid),
    .s_ready (s_weights_tready),
    .s_data  (s_weights_tdata),
    .cfg     (cfg_bus.decode)
  );

  row_sequencer u_seq (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .pix_valid (pix_valid),
    .pix_ready (pix_ready),
    .pix_data  (pix_data),
    .cfg       (cfg_bus.seq),
    .row       (row_bus.src)
  );

  conv_beat_assembler u_asm (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .row     (row_bus.sink),
    .cfg     (cfg_bus.result),
    .m_valid (m_conv_tvalid),
    .m_ready (m_conv_tready),
    .m_data  (m_data)
  );

  assign m_conv_tdata_pixels  = m_data.pixels;
  assign m_conv_tdata_weights = m_data.weights;
  assign m_conv_tuser         = m_data.tuser;
  assign m_conv_tlast         = m_data.last;

endmodule

// File: conv_beat_assembler.sv
`timescale 1ns/1ns

module conv_beat_assembler import conv_stream_pkg::*; (
  input  logic       aclk,
  input  logic       rst_n,
  row_if.sink        row,
  cfg_if.result      cfg,
  output logic       m_valid,
  input  logic       m_ready,
  output conv_beat_t m_data
);

  conv_beat_t beat;
  logic       m_take;

  always_comb begin
    beat.pixels  = row.pixels;
    beat.weights = row.weights;
    beat.tuser   = row.tuser;
    beat.last    = row.last;
  end

  axis_slice #(
    .payload_t (conv_beat_t)
  ) u_out_slice (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .in_valid  (row.valid),
    .in_ready  (row.ready),
    .in_data   (beat),
    .out_valid (m_valid),
    .out_ready (m_ready),
    .out_data  (m_data)
  );

  assign m_take = m_valid && m_ready;

  // Final beat of the layer leaves the pipe.
  assign cfg.layer_done = m_take && m_data.last;

endmodule

// File: row_sequencer.sv
`timescale 1ns/1ns

module row_sequencer import conv_geom_pkg::*, conv_stream_pkg::*; (
  input  logic        aclk,
  input  logic        rst_n,
  input  logic        pix_valid,
  output logic        pix_ready,
  input  pixel_beat_t pix_data,
  cfg_if.seq          cfg,
  row_if.src          row
);

  pixel_beat_t            beat;
  logic                   full;
  logic                   done;
  logic [krow_bits-1:0]   krow;
  logic [krow_bits-1:0]   krow_last;
  logic [krow_bits-1:0]   base;
  logic [cin_bits-1:0]    nxt_ci;
  logic [cols_bits-1:0]   nxt_col;
  logic [blocks_bits-1:0] nxt_blk;
  logic                   cin_end, col_end, blk_end, layer_end;
  logic [cin_bits-1:0]    cur_ci;
  logic                   cur_top, cur_bottom, cur_col_last, cur_cin_last, cur_final;
  logic                   load, row_take, row_end;

  assign krow_last = cfg.is_1x1 ? '0 : krow_bits'(kernel_h_max - 1);
  assign base      = cfg.is_1x1 ? krow_bits'(1) : krow;

  assign cin_end   = (nxt_ci == cfg.cin - 1'b1);
  assign col_end   = (nxt_col == cfg.cols - 1'b1);
  assign blk_end   = (nxt_blk == cfg.blocks - 1'b1);
  assign layer_end = cin_end && col_end && blk_end;

  assign row_take  = row.valid && row.ready;
  assign row_end   = row_take && (krow == krow_last);
  // Stops after the layer's final beat until the next layer is loaded.
  assign pix_ready = cfg.loaded && !done && (!full || row_end);
  assign load      = pix_valid && pix_ready;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      full    <= 1'b0;
      done    <= 1'b0;
      krow    <= '0;
      nxt_ci  <= '0;
      nxt_col <= '0;
      nxt_blk <= '0;
    end else begin
      if (load) full <= 1'b1;
      else if (row_end) full <= 1'b0;
      if (load || row_end) krow <= '0;
      else if (row_take) krow <= krow + 1'b1;
      if (!cfg.loaded) done <= 1'b0;
      else if (load && layer_end) done <= 1'b1;
      if (load) begin
        nxt_ci <= cin_end ? '0 : nxt_ci + 1'b1;
        if (cin_end) nxt_col <= col_end ? '0 : nxt_col + 1'b1;
        if (cin_end && col_end) nxt_blk <= blk_end ? '0 : nxt_blk + 1'b1;
      end
    end
  end

  // Position of the held beat.
  always_ff @(posedge aclk) begin
    if (load) begin
      beat         <= pix_data;
      cur_ci       <= nxt_ci;
      cur_top      <= (nxt_blk == '0);
      cur_bottom   <= blk_end;
      cur_col_last <= col_end;
      cur_cin_last <= cin_end;
      cur_final    <= layer_end;
    end
  end

  assign cfg.w_addr = cfg.is_1x1 ? w_addr_bits'(cur_ci)
                    : w_addr_bits'(cur_ci) * w_addr_bits'(kernel_h_max) + w_addr_bits'(krow);

  assign row.valid   = full;
  assign row.weights = cfg.w_row;
  assign row.last    = cur_final && (krow == krow_last);

  always_comb begin
    for (int u = 0; u < units; u++) begin
      row.pixels[u] = beat[base + u]; // Rows k and k+1.
    end
  end

  always_comb begin
    row.tuser                               = '0;
    row.tuser[i_is_1x1]                     = cfg.is_1x1;
    row.tuser[i_is_top_block]               = cur_top;
    row.tuser[i_is_bottom_block]            = cur_bottom;
    row.tuser[i_is_col_last]                = cur_col_last;
    row.tuser[i_is_cin_last]                = cur_cin_last;
    row.tuser[i_kernel_row +: krow_bits]    = cfg.is_1x1 ? '0 : krow;
  end

endmodule

// File: conv_config_decode.sv
`timescale 1ns/1ns

module conv_config_decode import conv_geom_pkg::*, conv_stream_pkg::*; (
  input  logic                          aclk,
  input  logic                          rst_n,
  input  logic                          s_valid,
  output logic                          s_ready,
  input  logic [w_words*word_width-1:0] s_data,
  cfg_if.decode                         cfg
);

  weight_row_t            w_mem [w_rows_max];
  weight_row_t            beat;
  logic                   take;
  logic                   have_header;
  logic                   loaded;
  logic [w_addr_bits-1:0] w_cnt;
  logic [w_addr_bits-1:0] w_last;
  logic                   is_1x1;
  logic [cin_bits-1:0]    cin;
  logic [cols_bits-1:0]   cols;
  logic [blocks_bits-1:0] blocks;

  assign beat    = s_data;
  assign s_ready = !loaded;
  assign take    = s_valid && s_ready;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      have_header <= 1'b0;
      loaded      <= 1'b0;
      w_cnt       <= '0;
    end else if (cfg.layer_done) begin
      loaded <= 1'b0; // Next beat is a header again.
    end else if (take) begin
      if (!have_header) begin
        have_header <= 1'b1;
        w_cnt       <= '0;
      end else begin
        w_cnt <= w_cnt + 1'b1;
        if (w_cnt == w_last) begin
          loaded      <= 1'b1;
          have_header <= 1'b0;
        end
      end
    end
  end

  // Header fields.
  always_ff @(posedge aclk) begin
    if (take && !have_header) begin
      is_1x1 <= (beat[h_kernel_h] == 8'd1);
      cin    <= cin_bits'(beat[h_cin]);
      cols   <= cols_bits'(beat[h_cols]);
      blocks <= blocks_bits'(beat[h_blocks]);
      w_last <= w_addr_bits'(beat[h_cin] * beat[h_kernel_h] - 1);
    end
  end

  always_ff @(posedge aclk) begin
    if (take && have_header) begin
      w_mem[w_cnt] <= beat;
    end
  end

  assign cfg.loaded = loaded;
  assign cfg.is_1x1 = is_1x1;
  assign cfg.cin    = cin;
  assign cfg.cols   = cols;
  assign cfg.blocks = blocks;
  assign cfg.w_row  = w_mem[cfg.w_addr];

endmodule

// File: axis_slice.sv
`timescale 1ns/1ns

module axis_slice #(
  parameter type payload_t = logic
) (
  input  logic     aclk,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic take;

  // Room when empty or the held item leaves this cycle.
  assign in_ready = !out_valid || out_ready;
  assign take     = in_valid && in_ready;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (take) begin
      out_data <= in_data;
    end
  end

endmodule

// File: conv_ifs.sv
`timescale 1ns/1ns

interface cfg_if import conv_geom_pkg::*, conv_stream_pkg::*; ();

  logic                   loaded;
  logic                   is_1x1;
  logic [cin_bits-1:0]    cin;
  logic [cols_bits-1:0]   cols;
  logic [blocks_bits-1:0] blocks;
  logic [w_addr_bits-1:0] w_addr;
  weight_row_t            w_row;  // Async read at w_addr.
  logic                   layer_done;

  modport decode (output loaded, is_1x1, cin, cols, blocks, w_row,
                  input  w_addr, layer_done);

  modport seq    (input  loaded, is_1x1, cin, cols, blocks, w_row,
                  output w_addr);

  modport result (output layer_done);

endinterface

interface row_if import conv_stream_pkg::*; ();

  logic                   valid;
  logic                   ready;
  pixel_row_t             pixels;
  weight_row_t            weights;
  logic [tuser_width-1:0] tuser;
  logic                   last;

  modport src  (output valid, pixels, weights, tuser, last,
                input  ready);

  modport sink (input  valid, pixels, weights, tuser, last,
                output ready);

endinterface

// File: conv_stream_pkg.sv
package conv_stream_pkg;

  import conv_geom_pkg::*;

  // Tuser layout on the conv-engine stream.
  localparam int i_is_1x1          = 0;
  localparam int i_is_top_block    = 1;
  localparam int i_is_bottom_block = 2;
  localparam int i_is_col_last     = 3;
  localparam int i_is_cin_last     = 4;
  localparam int i_kernel_row      = 5; // Two bits wide.
  localparam int tuser_width       = 7;

  // Word positions in the layer header beat.
  localparam int h_kernel_h = 0;
  localparam int h_cin      = 1;
  localparam int h_cols     = 2;
  localparam int h_blocks   = 3;

  // Word i sits at bits [i*word_width +: word_width].
  typedef logic [im_in_words-1:0][word_width-1:0] pixel_beat_t;
  typedef logic [units-1:0][word_width-1:0]       pixel_row_t;
  typedef logic [w_words-1:0][word_width-1:0]     weight_row_t;

  typedef struct packed {
    pixel_row_t               pixels;
    weight_row_t              weights;
    logic [tuser_width-1:0]   tuser;
    logic                     last;
  } conv_beat_t;

endpackage

// File: conv_geom_pkg.sv
package conv_geom_pkg;

  localparam int word_width   = 8;
  localparam int units        = 2;
  localparam int cores        = 2;
  localparam int kernel_w_max = 3;
  localparam int kernel_h_max = 3;

  // Units plus the top and bottom edge rows.
  localparam int im_in_words = 4;

  localparam int cin_max    = 4;
  localparam int cols_max   = 8;
  localparam int blocks_max = 4;

  localparam int w_words    = cores * kernel_w_max;
  localparam int w_rows_max = cin_max * kernel_h_max;

  // Counter widths hold the full count, not only the last index.
  localparam int cin_bits    = $clog2(cin_max + 1);
  localparam int cols_bits   = $clog2(cols_max + 1);
  localparam int blocks_bits = $clog2(blocks_max + 1);
  localparam int w_addr_bits = $clog2(w_rows_max);
  localparam int krow_bits   = $clog2(kernel_h_max);

endpackage
